//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cp0_top
FILELIST  = cp0_top.f
PASS_MSG  = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- cp0_ctrl.sv
`timescale 1ns/1ps

module cp0_ctrl #(
	parameter cp0_pkg::word_t EXCEPTION_BASE = 32'hBFC0_0200
) (
	input  logic                clk,
	input  logic                reset,
	input  cp0_pkg::cp0_op_t    op,
	input  cp0_pkg::cp0_addr_t  wa,
	input  cp0_pkg::word_t      wd,
	input  cp0_pkg::word_t      pc,
	input  cp0_pkg::word_t      vaddr,
	input  cp0_pkg::word_t      int_pc,
	input  logic                is_slot,
	input  logic                int_slot,
	input  cp0_pkg::exc_code_t  exc_code,
	input  logic                use_pc,
	input  logic                use_vaddr,
	input  logic                int_take,
	input  logic                ti,
	output logic                count_we,
	output logic                compare_we,
	output cp0_pkg::status_t    status,
	output cp0_pkg::cause_t     cause,
	output cp0_pkg::word_t      epc,
	output cp0_pkg::word_t      bad_vaddr,
	output cp0_pkg::word_t      ebase,
	output logic [2:0]          config0_k,
	output logic                trap_taken,
	output cp0_pkg::word_t      entrance
);

	cp0_pkg::cause_t    cause_q;
	cp0_pkg::exc_code_t trap_code;
	cp0_pkg::word_t     trap_pc;
	logic               trap_slot;
	logic               exc_taken;
	logic               mtc0_we;

	// interrupt wins over a synchronous exception in the same cycle
	assign exc_taken = (op == cp0_pkg::OP_EXC) && !int_take;
	assign trap_taken = int_take || (op == cp0_pkg::OP_EXC);
	assign mtc0_we = (op == cp0_pkg::OP_MTC0) && !trap_taken;

	assign trap_code = int_take ? cp0_pkg::INT : exc_code;
	assign trap_pc = int_take ? int_pc : pc;
	assign trap_slot = int_take ? int_slot : is_slot;

	assign count_we = mtc0_we && (wa == {cp0_pkg::REG_COUNT, 3'd0});
	assign compare_we = mtc0_we && (wa == {cp0_pkg::REG_COMPARE, 3'd0});

	// cause is stored without ti, the live timer flag is merged here
	always_comb begin
		cause = cause_q;
		cause.ti = ti;
	end

	assign entrance = ebase + cp0_pkg::EXC_OFFSET;

	always_ff @(posedge clk) begin
		if (reset) begin
			status <= '0;
			cause_q <= '0;
			ebase <= EXCEPTION_BASE;
			config0_k <= cp0_pkg::CONFIG0_BASE[2:0];
		end else begin
			if (trap_taken) begin
				cause_q.exc_code <= trap_code;
				// nested traps keep the first return context
				if (!status.exl) begin
					cause_q.bd <= trap_slot;
				end
				status.exl <= 1'b1;
			end else if (mtc0_we) begin
				case (wa)
					{cp0_pkg::REG_STATUS, 3'd0}: begin
						status <= cp0_pkg::status_t'((status & ~cp0_pkg::STATUS_WMASK) |
							(wd & cp0_pkg::STATUS_WMASK));
					end
					{cp0_pkg::REG_CAUSE, 3'd0}: begin
						cause_q <= cp0_pkg::cause_t'((cause_q & ~cp0_pkg::CAUSE_WMASK) |
							(wd & cp0_pkg::CAUSE_WMASK));
					end
					{cp0_pkg::REG_PRID, 3'd1}: begin
						ebase <= (ebase & ~cp0_pkg::EBASE_WMASK) |
							(wd & cp0_pkg::EBASE_WMASK);
					end
					{cp0_pkg::REG_CONFIG, 3'd0}: begin
						config0_k <= wd[2:0];
					end
					default: begin
					end
				endcase
			end
			// eret always drops exl, even alongside a trap
			if (op == cp0_pkg::OP_ERET) begin
				status.exl <= 1'b0;
			end
		end
	end

	// return address and faulting address
	always_ff @(posedge clk) begin
		if (trap_taken && !status.exl) begin
			epc <= trap_slot ? trap_pc - 32'd4 : trap_pc;
		end else if (mtc0_we && (wa == {cp0_pkg::REG_EPC, 3'd0})) begin
			epc <= wd;
		end
		if (exc_taken && use_pc) begin
			bad_vaddr <= pc;
		end else if (exc_taken && use_vaddr) begin
			bad_vaddr <= vaddr;
		end
	end

	a_op_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(op));

endmodule

//--- cp0_exc_prio.sv
`timescale 1ns/1ps

module cp0_exc_prio (
	input  cp0_pkg::exc_flags_t exc_flags,
	output cp0_pkg::exc_code_t  exc_code,
	output logic                use_vaddr,
	output logic                use_pc
);

	// fixed priority from the fetch side through decode and execute to memory
	always_comb begin
		exc_code = cp0_pkg::INT;
		use_pc = 1'b0;
		use_vaddr = 1'b0;
		if (exc_flags.adel_f) begin
			exc_code = cp0_pkg::ADEL;
			use_pc = 1'b1;
		end else if (exc_flags.ri) begin
			exc_code = cp0_pkg::RI;
		end else if (exc_flags.ov) begin
			exc_code = cp0_pkg::OV;
		end else if (exc_flags.bp) begin
			exc_code = cp0_pkg::BP;
		end else if (exc_flags.sys) begin
			exc_code = cp0_pkg::SYS;
		end else if (exc_flags.adel_d) begin
			exc_code = cp0_pkg::ADEL;
			use_vaddr = 1'b1;
		end else if (exc_flags.ades_d) begin
			exc_code = cp0_pkg::ADES;
			use_vaddr = 1'b1;
		end else if (exc_flags.cpu) begin
			exc_code = cp0_pkg::CPU;
		end else if (exc_flags.tr) begin
			exc_code = cp0_pkg::TR;
		end
	end

endmodule

//--- cp0_int_ctrl.sv
`timescale 1ns/1ps

module cp0_int_ctrl (
	input  logic       clk,
	input  logic       reset,
	input  logic       ie,
	input  logic       exl,
	input  logic [7:0] im,
	input  logic [1:0] ip_sw,
	input  logic       ti,
	input  logic [5:0] ext_int,
	input  logic       int_accept,
	output logic       int_now,
	output logic       int_take,
	output logic       is_int
);

	logic [7:0] pending;
	logic       int_held;

	// timer shares line 7 with the top external line
	assign pending = {ext_int, 2'b00} | {6'b0, ip_sw} | {ti, 7'b0};

	assign int_now = ie && !exl && (|(pending & im));
	assign int_take = int_accept && (int_now || int_held);
	assign is_int = int_now || int_held;

	// hold a request the pipeline could not take yet
	always_ff @(posedge clk) begin
		if (reset) begin
			int_held <= 1'b0;
		end else if (int_accept) begin
			int_held <= 1'b0;
		end else if (int_now) begin
			int_held <= 1'b1;
		end
	end

endmodule

//--- cp0_pkg.sv
package cp0_pkg;

	typedef logic [31:0] word_t;

	// upper five bits register number, lower three bits select
	typedef logic [7:0] cp0_addr_t;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_MTC0,
		OP_EXC,
		OP_ERET
	} cp0_op_t;

	typedef enum logic [4:0] {
		INT  = 5'd0,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		CPU  = 5'd11,
		OV   = 5'd12,
		TR   = 5'd13
	} exc_code_t;

	typedef struct packed {
		logic adel_f;
		logic ri;
		logic ov;
		logic bp;
		logic sys;
		logic adel_d;
		logic ades_d;
		logic cpu;
		logic tr;
	} exc_flags_t;

	typedef struct packed {
		logic [2:0] zero_31;
		logic       cu0;
		logic [4:0] zero_27;
		logic       bev;
		logic [5:0] zero_21;
		logic [7:0] im;
		logic [2:0] zero_7;
		logic       um;
		logic       zero_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic       bd;
		logic       ti;
		logic [5:0] zero_29;
		logic       iv;
		logic [6:0] zero_22;
		logic [7:0] ip;
		logic       zero_7;
		exc_code_t  exc_code;
		logic [1:0] zero_1;
	} cause_t;

	// register numbers
	localparam logic [4:0] REG_BADVADDR = 5'd8;
	localparam logic [4:0] REG_COUNT    = 5'd9;
	localparam logic [4:0] REG_COMPARE  = 5'd11;
	localparam logic [4:0] REG_STATUS   = 5'd12;
	localparam logic [4:0] REG_CAUSE    = 5'd13;
	localparam logic [4:0] REG_EPC      = 5'd14;
	localparam logic [4:0] REG_PRID     = 5'd15;
	localparam logic [4:0] REG_CONFIG   = 5'd16;

	localparam word_t PRID_VALUE    = 32'h0000_4220;
	// low three bits come from the writable k0 field
	localparam word_t CONFIG0_BASE  = 32'h8000_0480;
	localparam word_t CONFIG1_VALUE = 32'h2029_1480;
	localparam word_t EXC_OFFSET    = 32'h0000_0180;

	// writable bits for move-to-coprocessor
	localparam word_t STATUS_WMASK = 32'h1040_FF17;
	localparam word_t CAUSE_WMASK  = 32'h0080_0300;
	localparam word_t EBASE_WMASK  = 32'h3FFF_F000;

endpackage

//--- cp0_read_mux.sv
`timescale 1ns/1ps

module cp0_read_mux (
	input  cp0_pkg::cp0_addr_t ra,
	input  cp0_pkg::status_t   status,
	input  cp0_pkg::cause_t    cause,
	input  cp0_pkg::word_t     bad_vaddr,
	input  cp0_pkg::word_t     count,
	input  cp0_pkg::word_t     compare,
	input  cp0_pkg::word_t     epc,
	input  cp0_pkg::word_t     ebase,
	input  logic [2:0]         config0_k,
	output cp0_pkg::word_t     rd
);

	logic [4:0] reg_num;
	logic [2:0] sel;

	assign reg_num = ra[7:3];
	assign sel = ra[2:0];

	always_comb begin
		rd = '0;
		if (sel == 3'd0) begin
			case (reg_num)
				cp0_pkg::REG_BADVADDR: rd = bad_vaddr;
				cp0_pkg::REG_COUNT:    rd = count;
				cp0_pkg::REG_COMPARE:  rd = compare;
				cp0_pkg::REG_STATUS:   rd = status;
				cp0_pkg::REG_CAUSE:    rd = cause;
				cp0_pkg::REG_EPC:      rd = epc;
				cp0_pkg::REG_PRID:     rd = cp0_pkg::PRID_VALUE;
				cp0_pkg::REG_CONFIG:   rd = {cp0_pkg::CONFIG0_BASE[31:3], config0_k};
				default:               rd = '0;
			endcase
		end else if (sel == 3'd1) begin
			// ebase sits behind prid select 1
			case (reg_num)
				cp0_pkg::REG_PRID:   rd = ebase;
				cp0_pkg::REG_CONFIG: rd = cp0_pkg::CONFIG1_VALUE;
				default:             rd = '0;
			endcase
		end
	end

endmodule

//--- cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer #(
	parameter int COUNT_DIV = 2
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            count_we,
	input  logic            compare_we,
	input  cp0_pkg::word_t  wd,
	output cp0_pkg::word_t  count,
	output cp0_pkg::word_t  compare,
	output logic            ti
);

	localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	assign tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			count <= '0;
			// all ones so no match until compare is programmed
			compare <= '1;
			ti <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (count_we) begin
				count <= wd;
			end else if (tick) begin
				count <= count + 32'd1;
			end
			if (compare_we) begin
				compare <= wd;
			end
			// writing compare acknowledges the timer interrupt
			if (compare_we) begin
				ti <= 1'b0;
			end else if (count == compare) begin
				ti <= 1'b1;
			end
		end
	end

	a_single_timer_write: assert property (@(posedge clk) disable iff (reset)
		!(count_we && compare_we));

endmodule

//--- cp0_top.f
cp0_pkg.sv
cp0_exc_prio.sv
cp0_timer.sv
cp0_int_ctrl.sv
cp0_ctrl.sv
cp0_read_mux.sv
cp0_top.sv
tb_cp0_top.sv

//--- cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
	parameter cp0_pkg::word_t EXCEPTION_BASE = 32'hBFC0_0200,
	parameter int             COUNT_DIV = 2
) (
	input  logic                clk,
	input  logic                reset,
	input  cp0_pkg::cp0_op_t    op,
	input  cp0_pkg::cp0_addr_t  wa,
	input  cp0_pkg::word_t      wd,
	input  cp0_pkg::word_t      pc,
	input  logic                is_slot,
	input  cp0_pkg::exc_flags_t exc_flags,
	input  cp0_pkg::word_t      vaddr,
	input  logic [5:0]          ext_int,
	input  logic                int_accept,
	input  cp0_pkg::word_t      int_pc,
	input  logic                int_slot,
	input  cp0_pkg::cp0_addr_t  ra,
	input  cp0_pkg::cp0_addr_t  ra_m,
	output cp0_pkg::word_t      rd,
	output cp0_pkg::word_t      rd_m,
	output cp0_pkg::word_t      epc,
	output cp0_pkg::status_t    status,
	output cp0_pkg::cause_t     cause,
	output logic                is_int,
	output logic                trap_taken,
	output cp0_pkg::word_t      entrance
);

	cp0_pkg::exc_code_t exc_code;
	logic               use_vaddr;
	logic               use_pc;
	logic               int_take;
	logic               count_we;
	logic               compare_we;
	cp0_pkg::word_t     count;
	cp0_pkg::word_t     compare;
	logic               ti;
	cp0_pkg::word_t     bad_vaddr;
	cp0_pkg::word_t     ebase;
	logic [2:0]         config0_k;

	cp0_exc_prio u_exc_prio (
		.exc_flags (exc_flags),
		.exc_code  (exc_code),
		.use_vaddr (use_vaddr),
		.use_pc    (use_pc)
	);

	cp0_timer #(.COUNT_DIV(COUNT_DIV)) u_timer (
		.clk        (clk),
		.reset      (reset),
		.count_we   (count_we),
		.compare_we (compare_we),
		.wd         (wd),
		.count      (count),
		.compare    (compare),
		.ti         (ti)
	);

	// int_now is folded into int_take and is_int inside the block
	cp0_int_ctrl u_int_ctrl (
		.clk        (clk),
		.reset      (reset),
		.ie         (status.ie),
		.exl        (status.exl),
		.im         (status.im),
		.ip_sw      (cause.ip[1:0]),
		.ti         (ti),
		.ext_int    (ext_int),
		.int_accept (int_accept),
		.int_now    (),
		.int_take   (int_take),
		.is_int     (is_int)
	);

	cp0_ctrl #(.EXCEPTION_BASE(EXCEPTION_BASE)) u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.op         (op),
		.wa         (wa),
		.wd         (wd),
		.pc         (pc),
		.vaddr      (vaddr),
		.int_pc     (int_pc),
		.is_slot    (is_slot),
		.int_slot   (int_slot),
		.exc_code   (exc_code),
		.use_pc     (use_pc),
		.use_vaddr  (use_vaddr),
		.int_take   (int_take),
		.ti         (ti),
		.count_we   (count_we),
		.compare_we (compare_we),
		.status     (status),
		.cause      (cause),
		.epc        (epc),
		.bad_vaddr  (bad_vaddr),
		.ebase      (ebase),
		.config0_k  (config0_k),
		.trap_taken (trap_taken),
		.entrance   (entrance)
	);

	// decode stage read port
	cp0_read_mux u_rd_d (
		.ra        (ra),
		.status    (status),
		.cause     (cause),
		.bad_vaddr (bad_vaddr),
		.count     (count),
		.compare   (compare),
		.epc       (epc),
		.ebase     (ebase),
		.config0_k (config0_k),
		.rd        (rd)
	);

	// memory stage read port
	cp0_read_mux u_rd_m (
		.ra        (ra_m),
		.status    (status),
		.cause     (cause),
		.bad_vaddr (bad_vaddr),
		.count     (count),
		.compare   (compare),
		.epc       (epc),
		.ebase     (ebase),
		.config0_k (config0_k),
		.rd        (rd_m)
	);

endmodule

//--- tb_cp0_top.sv
`timescale 1ns/1ps

module tb_cp0_top;

	localparam int             CLK_PERIOD = 8;
	localparam cp0_pkg::word_t EXC_BASE = 32'hBFC0_0200;
	localparam int             DIV = 2;

	// writable bits of status, cause and ebase
	localparam cp0_pkg::word_t STATUS_MASK = 32'h1040_FF17;
	localparam cp0_pkg::word_t CAUSE_MASK = 32'h0080_0300;
	localparam cp0_pkg::word_t EBASE_MASK = 32'h3FFF_F000;

	localparam cp0_pkg::cp0_addr_t A_BADVADDR = {5'd8, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_COUNT = {5'd9, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_COMPARE = {5'd11, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_STATUS = {5'd12, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_CAUSE = {5'd13, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_EPC = {5'd14, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_PRID = {5'd15, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_EBASE = {5'd15, 3'd1};
	localparam cp0_pkg::cp0_addr_t A_CONFIG0 = {5'd16, 3'd0};
	localparam cp0_pkg::cp0_addr_t A_CONFIG1 = {5'd16, 3'd1};

	// exception flag bits with adel_f as the msb
	localparam logic [8:0] F_ADEL_F = 9'h100;
	localparam logic [8:0] F_RI = 9'h080;
	localparam logic [8:0] F_OV = 9'h040;
	localparam logic [8:0] F_BP = 9'h020;
	localparam logic [8:0] F_SYS = 9'h010;
	localparam logic [8:0] F_ADEL_D = 9'h008;
	localparam logic [8:0] F_ADES_D = 9'h004;
	localparam logic [8:0] F_TR = 9'h001;

	typedef enum {CK_NONE, CK_RD, CK_TRAP, CK_INT, CK_TI, CK_CODE, CK_ENT, CK_TIMER} check_kind_t;

	typedef struct {
		string               name;
		cp0_pkg::cp0_op_t    op;
		cp0_pkg::cp0_addr_t  wa;
		cp0_pkg::word_t      wd;
		cp0_pkg::word_t      pc;
		logic                is_slot;
		cp0_pkg::exc_flags_t flags;
		cp0_pkg::word_t      vaddr;
		logic [5:0]          ext_int;
		logic                int_accept;
		cp0_pkg::word_t      int_pc;
		cp0_pkg::cp0_addr_t  ra;
		check_kind_t         kind;
		cp0_pkg::word_t      exp;
	} stim_row_t;

	logic                clk;
	logic                reset;
	cp0_pkg::cp0_op_t    op;
	cp0_pkg::cp0_addr_t  wa;
	cp0_pkg::word_t      wd;
	cp0_pkg::word_t      pc;
	logic                is_slot;
	cp0_pkg::exc_flags_t exc_flags;
	cp0_pkg::word_t      vaddr;
	logic [5:0]          ext_int;
	logic                int_accept;
	cp0_pkg::word_t      int_pc;
	logic                int_slot;
	cp0_pkg::cp0_addr_t  ra;
	cp0_pkg::cp0_addr_t  ra_m;
	cp0_pkg::word_t      rd;
	cp0_pkg::word_t      rd_m;
	cp0_pkg::word_t      epc;
	cp0_pkg::status_t    status;
	cp0_pkg::cause_t     cause;
	logic                is_int;
	logic                trap_taken;
	cp0_pkg::word_t      entrance;

	stim_row_t stim[$];
	logic      table_ready = 1'b0;

	cp0_top #(.EXCEPTION_BASE(EXC_BASE), .COUNT_DIV(DIV)) i_dut (
		.clk(clk), .reset(reset), .op(op), .wa(wa), .wd(wd), .pc(pc), .is_slot(is_slot),
		.exc_flags(exc_flags), .vaddr(vaddr), .ext_int(ext_int), .int_accept(int_accept),
		.int_pc(int_pc), .int_slot(int_slot), .ra(ra), .ra_m(ra_m), .rd(rd), .rd_m(rd_m),
		.epc(epc), .status(status), .cause(cause), .is_int(is_int),
		.trap_taken(trap_taken), .entrance(entrance)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic stim_row_t blank_row(input string name);
		stim_row_t r;
		r.name = name;
		r.op = cp0_pkg::OP_NONE;
		r.wa = '0;
		r.wd = '0;
		r.pc = '0;
		r.is_slot = 1'b0;
		r.flags = '0;
		r.vaddr = '0;
		r.ext_int = '0;
		r.int_accept = 1'b0;
		r.int_pc = '0;
		r.ra = '0;
		r.kind = CK_NONE;
		r.exp = '0;
		return r;
	endfunction

	task automatic add_read(input string name, input cp0_pkg::cp0_addr_t addr,
			input check_kind_t kind, input cp0_pkg::word_t exp);
		stim_row_t r;
		r = blank_row(name);
		r.ra = addr;
		r.kind = kind;
		r.exp = exp;
		stim.push_back(r);
	endtask

	task automatic add_write(input string name, input cp0_pkg::cp0_addr_t addr,
			input cp0_pkg::word_t data, input check_kind_t kind);
		stim_row_t r;
		r = blank_row(name);
		r.op = cp0_pkg::OP_MTC0;
		r.wa = addr;
		r.wd = data;
		r.kind = kind;
		stim.push_back(r);
	endtask

	// every exception row also checks trap_taken in its own cycle
	task automatic add_exc(input string name, input cp0_pkg::word_t epc_in, input logic slot,
			input logic [8:0] flags, input cp0_pkg::word_t addr);
		stim_row_t r;
		r = blank_row(name);
		r.op = cp0_pkg::OP_EXC;
		r.pc = epc_in;
		r.is_slot = slot;
		r.flags = cp0_pkg::exc_flags_t'(flags);
		r.vaddr = addr;
		r.kind = CK_TRAP;
		r.exp = 32'd1;
		stim.push_back(r);
	endtask

	task automatic add_eret(input string name);
		stim_row_t r;
		r = blank_row(name);
		r.op = cp0_pkg::OP_ERET;
		stim.push_back(r);
	endtask

	task automatic add_irq(input string name, input logic [5:0] lines, input logic accept,
			input cp0_pkg::word_t ipc, input check_kind_t kind, input cp0_pkg::word_t exp);
		stim_row_t r;
		r = blank_row(name);
		r.ext_int = lines;
		r.int_accept = accept;
		r.int_pc = ipc;
		r.kind = kind;
		r.exp = exp;
		stim.push_back(r);
	endtask

	task automatic apply_row(input stim_row_t r);
		op <= r.op;
		wa <= r.wa;
		wd <= r.wd;
		pc <= r.pc;
		is_slot <= r.is_slot;
		exc_flags <= r.flags;
		vaddr <= r.vaddr;
		ext_int <= r.ext_int;
		int_accept <= r.int_accept;
		int_pc <= r.int_pc;
		int_slot <= 1'b0;
		ra <= r.ra;
		ra_m <= r.ra;
	endtask

	task automatic check_word(input string name, input cp0_pkg::word_t exp,
			input cp0_pkg::word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %b actual %b", name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_code(input string name, input cp0_pkg::exc_code_t exp,
			input cp0_pkg::exc_code_t act);
		if (act !== exp) begin
			$display("MISMATCH %s expected %s actual %s", name, exp.name(), act.name());
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// compare match plus one edge for ti and slack for the divider phase
	task automatic wait_timer_irq(input string name);
		int limit;
		int cycles;
		limit = 10 * DIV + 4;
		cycles = 0;
		while (!(cause.ti === 1'b1 && is_int === 1'b1) && cycles < limit) begin
			@(posedge clk);
			apply_row(blank_row("idle"));
			@(negedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			$display("%s: timer interrupt did not rise within %0d cycles", name, limit);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic build_table();
		cp0_pkg::word_t r_status;
		cp0_pkg::word_t r_cause;
		cp0_pkg::word_t r_epc;
		cp0_pkg::word_t r_ebase;
		// keep ie clear so random im and ip bits cannot raise an interrupt
		r_status = $urandom & ~32'h1;
		r_cause = $urandom;
		r_epc = $urandom;
		r_ebase = $urandom;
		add_read("prid", A_PRID, CK_RD, cp0_pkg::PRID_VALUE);
		add_read("config0", A_CONFIG0, CK_RD, cp0_pkg::CONFIG0_BASE);
		add_read("config1", A_CONFIG1, CK_RD, cp0_pkg::CONFIG1_VALUE);
		add_read("status_reset", A_STATUS, CK_RD, 32'h0);
		add_read("entrance_reset", A_PRID, CK_ENT, EXC_BASE + 32'h180);
		add_write("wr_status", A_STATUS, r_status, CK_NONE);
		add_read("rd_status", A_STATUS, CK_RD, r_status & STATUS_MASK);
		add_write("wr_cause", A_CAUSE, r_cause, CK_NONE);
		add_read("rd_cause", A_CAUSE, CK_RD, r_cause & CAUSE_MASK);
		add_write("wr_epc", A_EPC, r_epc, CK_NONE);
		add_read("rd_epc", A_EPC, CK_RD, r_epc);
		add_write("wr_ebase", A_EBASE, r_ebase, CK_NONE);
		add_read("rd_ebase", A_EBASE, CK_RD, (EXC_BASE & ~EBASE_MASK) | (r_ebase & EBASE_MASK));
		add_write("clr_status", A_STATUS, 32'h0, CK_NONE);
		add_write("clr_cause", A_CAUSE, 32'h0, CK_NONE);
		add_exc("exc_multi", 32'h0000_1000, 1'b0, F_RI | F_OV | F_SYS | F_TR, 32'h0);
		add_read("code_multi", A_CAUSE, CK_CODE, 32'(cp0_pkg::RI));
		add_read("epc_multi", A_EPC, CK_RD, 32'h0000_1000);
		add_exc("exc_nested", 32'h0000_2000, 1'b0, F_BP, 32'h0);
		add_read("epc_nested", A_EPC, CK_RD, 32'h0000_1000);
		add_read("code_nested", A_CAUSE, CK_CODE, 32'(cp0_pkg::BP));
		add_eret("eret_1");
		add_read("exl_clear", A_STATUS, CK_RD, 32'h0);
		add_exc("exc_slot", 32'h0000_3000, 1'b1, F_ADEL_D, 32'hDEAD_BEE1);
		add_read("epc_slot", A_EPC, CK_RD, 32'h0000_2FFC);
		// bd set and code 4 in bits 6:2
		add_read("bd_slot", A_CAUSE, CK_RD, 32'h8000_0010);
		add_read("badvaddr_data", A_BADVADDR, CK_RD, 32'hDEAD_BEE1);
		add_eret("eret_2");
		add_exc("exc_fetch", 32'h0000_4001, 1'b0, F_ADEL_F | F_ADES_D, 32'h0000_8888);
		add_read("badvaddr_fetch", A_BADVADDR, CK_RD, 32'h0000_4001);
		add_read("code_fetch", A_CAUSE, CK_CODE, 32'(cp0_pkg::ADEL));
		add_read("epc_fetch", A_EPC, CK_RD, 32'h0000_4001);
		add_eret("eret_3");
		// ie plus im bit 2 for ext_int[0]
		add_write("int_enable", A_STATUS, 32'h0000_0401, CK_NONE);
		add_irq("int_raise", 6'h01, 1'b0, 32'h0, CK_INT, 32'd1);
		add_irq("int_held", 6'h00, 1'b0, 32'h0, CK_INT, 32'd1);
		add_irq("int_accept", 6'h00, 1'b1, 32'h0000_5004, CK_TRAP, 32'd1);
		add_read("code_int", A_CAUSE, CK_CODE, 32'(cp0_pkg::INT));
		add_read("epc_int", A_EPC, CK_RD, 32'h0000_5004);
		add_irq("int_exl", 6'h01, 1'b0, 32'h0, CK_INT, 32'd0);
		add_eret("eret_int");
		add_write("mask_off", A_STATUS, 32'h0000_0001, CK_NONE);
		add_irq("int_masked", 6'h01, 1'b0, 32'h0, CK_INT, 32'd0);
		add_write("timer_enable", A_STATUS, 32'h0000_8001, CK_NONE);
		add_write("wr_count", A_COUNT, 32'h0000_0100, CK_NONE);
		add_write("wr_compare", A_COMPARE, 32'h0000_010A, CK_TIMER);
		add_write("ack_compare", A_COMPARE, 32'hFFFF_0000, CK_NONE);
		add_read("ti_clear", A_CAUSE, CK_TI, 32'd0);
	endtask

	initial begin
		wait (table_ready);
		#((stim.size() + 200) * CLK_PERIOD);
		$display("timeout: the test table did not finish in time");
		$display("FAIL: see errors above");
		$fatal(1);
	end

	initial begin
		stim_row_t r;
		void'($urandom(14));
		reset <= 1'b1;
		apply_row(blank_row("idle"));
		build_table();
		table_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		foreach (stim[i]) begin
			r = stim[i];
			@(posedge clk);
			apply_row(r);
			@(negedge clk);
			case (r.kind)
				CK_RD: begin
					check_word(r.name, r.exp, rd);
					check_word({r.name, "_m"}, r.exp, rd_m);
					// the direct epc and status outputs follow the registers
					if (r.ra == A_EPC) begin
						check_word({r.name, "_epc_out"}, r.exp, epc);
					end
					if (r.ra == A_STATUS) begin
						check_word({r.name, "_status_out"}, r.exp, status);
					end
				end
				CK_TRAP: check_bit(r.name, r.exp[0], trap_taken);
				CK_INT: check_bit(r.name, r.exp[0], is_int);
				CK_TI: check_bit(r.name, r.exp[0], cause.ti);
				CK_CODE: check_code(r.name, cp0_pkg::exc_code_t'(r.exp[4:0]), cause.exc_code);
				CK_ENT: check_word(r.name, r.exp, entrance);
				CK_TIMER: wait_timer_irq(r.name);
				default: begin
				end
			endcase
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule
